// ==== Makefile ====
TOP = refill_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f refill_unit.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f refill_unit.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir

// ==== refill_unit.f ====
rtl/refill_pkg.sv
rtl/miss_capture.sv
rtl/refill_arbiter.sv
rtl/lru_tracker.sv
rtl/refill_unit.sv
test/refill_unit_properties.sv
test/refill_unit_tb.sv

// ==== rtl/lru_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module lru_tracker #(
    parameter int NUM_WAYS = 4
) (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        hit_i,
    input  logic [$clog2(NUM_WAYS)-1:0] hit_way_i,
    input  logic                        refill_i,
    output logic [$clog2(NUM_WAYS)-1:0] victim_way_o
);

    localparam int WAY_BITS = $clog2(NUM_WAYS);

    // older_q[i][j] set means way i was used less recently than way j
    logic [NUM_WAYS-1:0][NUM_WAYS-1:0] older_q;
    logic [NUM_WAYS-1:0][NUM_WAYS-1:0] older_d;

    logic                touch;
    logic [WAY_BITS-1:0] touch_way;
    logic [WAY_BITS-1:0] victim_d;

    // Refill wins over a hit in the same cycle
    always_comb begin
        touch     = 1'b0;
        touch_way = hit_way_i;
        if (refill_i) begin
            touch     = 1'b1;
            touch_way = victim_way_o;
        end else if (hit_i) begin
            touch     = 1'b1;
        end
    end

    // Touched way becomes newer than every other way
    always_comb begin
        older_d = older_q;
        if (touch) begin
            for (int j = 0; j < NUM_WAYS; j++) begin
                older_d[touch_way][j] = 1'b0;
                older_d[j][touch_way] = (j != int'(touch_way));
            end
        end
    end

    // Victim is the way older than all the others
    always_comb begin
        victim_d = '0;
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (&(older_d[i] | (NUM_WAYS'(1) << i))) begin
                victim_d = WAY_BITS'(i);
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // Way 0 least recent, highest way most recent
            for (int i = 0; i < NUM_WAYS; i++) begin
                for (int j = 0; j < NUM_WAYS; j++) begin
                    older_q[i][j] <= (i < j);
                end
            end
            victim_way_o <= '0;
        end else begin
            older_q      <= older_d;
            victim_way_o <= victim_d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/miss_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module miss_capture (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              miss_i,
    input  refill_pkg::addr_t addr_i,
    input  logic              done_i,
    output logic              pending_o,
    output refill_pkg::addr_t line_addr_o
);

    localparam int ADDR_WIDTH       = refill_pkg::ADDR_WIDTH;
    localparam int LINE_OFFSET_BITS = refill_pkg::LINE_OFFSET_BITS;

    refill_pkg::addr_t aligned_addr;

    // Drop the byte offset so memory sees a line address
    assign aligned_addr = {addr_i[ADDR_WIDTH-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};

    // One outstanding miss per cache
    // A new strobe only comes once the previous refill has cleared pending
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_o <= 1'b0;
        end else if (miss_i) begin
            pending_o <= 1'b1;
        end else if (done_i) begin
            pending_o <= 1'b0;
        end
    end

    // Address is held until the next miss
    always_ff @(posedge clk_i) begin
        if (miss_i) begin
            line_addr_o <= aligned_addr;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/refill_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module refill_arbiter (
    input  logic              clk_i,
    input  logic              arst_n_i,
    // Pending misses from the capture stage
    input  logic              dc_pending_i,
    input  refill_pkg::addr_t dc_line_addr_i,
    input  logic              ic_pending_i,
    input  refill_pkg::addr_t ic_line_addr_i,
    // Main memory
    input  logic              mm_data_rdy_i,
    input  refill_pkg::line_t mm_data_i,
    output logic              mm_rd_req_o,
    output refill_pkg::addr_t mm_addr_o,
    // Refill toward the caches
    output logic              dc_refill_o,
    output refill_pkg::line_t dc_line_o,
    output logic              ic_refill_o,
    output refill_pkg::line_t ic_line_o
);

    refill_pkg::refill_state_e state_q;
    refill_pkg::refill_state_e state_d;

    logic              dc_want;
    logic              ic_want;
    logic              dc_done;
    logic              ic_done;
    logic              rd_req_d;
    refill_pkg::addr_t rd_addr_d;

    // Pending stays high during the refill pulse, so a miss that is being
    // returned right now must not be picked again
    assign dc_want = dc_pending_i && !dc_refill_o;
    assign ic_want = ic_pending_i && !ic_refill_o;

    assign dc_done = (state_q == refill_pkg::DC_WAIT) && mm_data_rdy_i;
    assign ic_done = (state_q == refill_pkg::IC_WAIT) && mm_data_rdy_i;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            refill_pkg::IDLE: begin
                // Data cache first
                if (dc_want) begin
                    state_d = refill_pkg::DC_REQ;
                end else if (ic_want) begin
                    state_d = refill_pkg::IC_REQ;
                end
            end
            refill_pkg::DC_REQ: begin
                state_d = refill_pkg::DC_WAIT;
            end
            refill_pkg::DC_WAIT: begin
                // Hand over to a waiting instruction miss
                if (mm_data_rdy_i) begin
                    state_d = ic_want ? refill_pkg::IC_REQ : refill_pkg::IDLE;
                end
            end
            refill_pkg::IC_REQ: begin
                state_d = refill_pkg::IC_WAIT;
            end
            refill_pkg::IC_WAIT: begin
                if (mm_data_rdy_i) begin
                    state_d = dc_want ? refill_pkg::DC_REQ : refill_pkg::IDLE;
                end
            end
            default: begin
                state_d = refill_pkg::IDLE;
            end
        endcase
    end

    // Read request follows the next state so it lines up with the REQ cycle
    assign rd_req_d  = (state_d == refill_pkg::DC_REQ) || (state_d == refill_pkg::IC_REQ);
    assign rd_addr_d = (state_d == refill_pkg::IC_REQ) ? ic_line_addr_i : dc_line_addr_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= refill_pkg::IDLE;
            mm_rd_req_o <= 1'b0;
            dc_refill_o <= 1'b0;
            ic_refill_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            mm_rd_req_o <= rd_req_d;
            dc_refill_o <= dc_done;
            ic_refill_o <= ic_done;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_req_d) begin
            mm_addr_o <= rd_addr_d;
        end
        if (dc_done) begin
            dc_line_o <= mm_data_i;
        end
        if (ic_done) begin
            ic_line_o <= mm_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/refill_pkg.sv ====
`default_nettype none

package refill_pkg;

    // Bus widths
    parameter int ADDR_WIDTH = 32;
    parameter int WORD_WIDTH = 32;
    parameter int LINE_WIDTH = 128;

    // Byte offset inside one line, cleared to align a miss address
    parameter int LINE_OFFSET_BITS = 4;

    // A byte address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // One store word on the bypass path
    typedef logic [WORD_WIDTH-1:0] word_t;

    // One cache line, same width for both caches
    typedef logic [LINE_WIDTH-1:0] line_t;

    // Store access size
    // 2'b00 byte, 2'b01 half, 2'b10 word
    typedef logic [1:0] mem_size_t;

    // Refill arbiter states
    typedef enum logic [2:0] {
        IDLE,
        DC_REQ,
        DC_WAIT,
        IC_REQ,
        IC_WAIT
    } refill_state_e;

endpackage

`default_nettype wire

// ==== rtl/refill_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module refill_unit #(
    parameter int DC_NUM_WAYS = 4,
    parameter int IC_NUM_WAYS = 4
) (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    // Data cache
    input  logic                           dc_miss_i,
    input  refill_pkg::addr_t              dc_addr_i,
    input  logic                           dc_hit_i,
    input  logic [$clog2(DC_NUM_WAYS)-1:0] dc_hit_way_i,
    input  logic                           dc_store_i,
    input  refill_pkg::addr_t              dc_store_addr_i,
    input  refill_pkg::word_t              dc_store_data_i,
    input  refill_pkg::mem_size_t          dc_store_size_i,
    output logic                           dc_refill_o,
    output refill_pkg::line_t              dc_line_o,
    output logic [$clog2(DC_NUM_WAYS)-1:0] dc_victim_way_o,
    // Instruction cache
    input  logic                           ic_miss_i,
    input  refill_pkg::addr_t              ic_addr_i,
    input  logic                           ic_hit_i,
    input  logic [$clog2(IC_NUM_WAYS)-1:0] ic_hit_way_i,
    output logic                           ic_refill_o,
    output refill_pkg::line_t              ic_line_o,
    output logic [$clog2(IC_NUM_WAYS)-1:0] ic_victim_way_o,
    // Main memory
    input  logic                           mm_data_rdy_i,
    input  refill_pkg::line_t              mm_data_i,
    output logic                           mm_rd_req_o,
    output refill_pkg::addr_t              mm_addr_o,
    output logic                           mm_wr_req_o,
    output refill_pkg::addr_t              mm_wr_addr_o,
    output refill_pkg::word_t              mm_wr_data_o,
    output refill_pkg::mem_size_t          mm_wr_size_o
);

    logic              dc_pending;
    refill_pkg::addr_t dc_line_addr;
    logic              ic_pending;
    refill_pkg::addr_t ic_line_addr;

    // Stores skip the refill path entirely
    assign mm_wr_req_o  = dc_store_i;
    assign mm_wr_addr_o = dc_store_addr_i;
    assign mm_wr_data_o = dc_store_data_i;
    assign mm_wr_size_o = dc_store_size_i;

    miss_capture u_dc_capture (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .miss_i      (dc_miss_i),
        .addr_i      (dc_addr_i),
        .done_i      (dc_refill_o),
        .pending_o   (dc_pending),
        .line_addr_o (dc_line_addr)
    );

    miss_capture u_ic_capture (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .miss_i      (ic_miss_i),
        .addr_i      (ic_addr_i),
        .done_i      (ic_refill_o),
        .pending_o   (ic_pending),
        .line_addr_o (ic_line_addr)
    );

    refill_arbiter u_arbiter (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .dc_pending_i   (dc_pending),
        .dc_line_addr_i (dc_line_addr),
        .ic_pending_i   (ic_pending),
        .ic_line_addr_i (ic_line_addr),
        .mm_data_rdy_i  (mm_data_rdy_i),
        .mm_data_i      (mm_data_i),
        .mm_rd_req_o    (mm_rd_req_o),
        .mm_addr_o      (mm_addr_o),
        .dc_refill_o    (dc_refill_o),
        .dc_line_o      (dc_line_o),
        .ic_refill_o    (ic_refill_o),
        .ic_line_o      (ic_line_o)
    );

    lru_tracker #(
        .NUM_WAYS (DC_NUM_WAYS)
    ) u_dc_lru (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .hit_i        (dc_hit_i),
        .hit_way_i    (dc_hit_way_i),
        .refill_i     (dc_refill_o),
        .victim_way_o (dc_victim_way_o)
    );

    lru_tracker #(
        .NUM_WAYS (IC_NUM_WAYS)
    ) u_ic_lru (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .hit_i        (ic_hit_i),
        .hit_way_i    (ic_hit_way_i),
        .refill_i     (ic_refill_o),
        .victim_way_o (ic_victim_way_o)
    );

endmodule

`default_nettype wire

// ==== test/refill_unit_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module refill_unit_properties (
    input logic clk_i,
    input logic arst_n_i,
    input logic rd_req_i,
    input logic dc_refill_i,
    input logic ic_refill_i,
    input logic dc_pending_i,
    input logic ic_pending_i
);

    // One request per REQ state
    a_single_req: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        rd_req_i |=> !rd_req_i
    ) else $error("mm_rd_req_o high on two consecutive cycles");

    a_one_refill: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !(dc_refill_i && ic_refill_i)
    ) else $error("dc_refill_o and ic_refill_o high together");

    // A read always serves a captured miss
    a_req_has_miss: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        rd_req_i |-> (dc_pending_i || ic_pending_i)
    ) else $error("mm_rd_req_o high with no pending miss");

    a_dc_refill_pulse: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        dc_refill_i |-> dc_pending_i ##1 !dc_refill_i
    ) else $error("dc_refill_o without a pending miss or longer than one cycle");

    a_ic_refill_pulse: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        ic_refill_i |-> ic_pending_i ##1 !ic_refill_i
    ) else $error("ic_refill_o without a pending miss or longer than one cycle");

endmodule

`default_nettype wire

// ==== test/refill_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module refill_unit_tb;

    localparam int NUM_WAYS      = 4;
    localparam int WAY_BITS      = $clog2(NUM_WAYS);
    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 8;
    localparam int IDLE_CYCLES   = 20;
    localparam int NUM_REFILLS   = 300;
    localparam int MAX_MEM_DELAY = 8;
    // Own refill plus one of the other cache served ahead of it
    localparam int WORST_REFILL  = 2 * (MAX_MEM_DELAY + 4);
    localparam int WATCHDOG_NS   =
        (RESET_CYCLES + IDLE_CYCLES + NUM_REFILLS * WORST_REFILL + 200) * CLK_PERIOD;

    typedef logic [WAY_BITS-1:0] way_t;

    logic                  clk_i;
    logic                  arst_n_i;
    logic                  dc_miss_i;
    refill_pkg::addr_t     dc_addr_i;
    logic                  dc_hit_i;
    way_t                  dc_hit_way_i;
    logic                  dc_store_i;
    refill_pkg::addr_t     dc_store_addr_i;
    refill_pkg::word_t     dc_store_data_i;
    refill_pkg::mem_size_t dc_store_size_i;
    logic                  dc_refill_o;
    refill_pkg::line_t     dc_line_o;
    way_t                  dc_victim_way_o;
    logic                  ic_miss_i;
    refill_pkg::addr_t     ic_addr_i;
    logic                  ic_hit_i;
    way_t                  ic_hit_way_i;
    logic                  ic_refill_o;
    refill_pkg::line_t     ic_line_o;
    way_t                  ic_victim_way_o;
    logic                  mm_data_rdy_i;
    refill_pkg::line_t     mm_data_i;
    logic                  mm_rd_req_o;
    refill_pkg::addr_t     mm_addr_o;
    logic                  mm_wr_req_o;
    refill_pkg::addr_t     mm_wr_addr_o;
    refill_pkg::word_t     mm_wr_data_o;
    refill_pkg::mem_size_t mm_wr_size_o;

    // Model state, index 0 is the data cache and 1 the instruction cache
    logic [31:0]       lcg_state;
    int                cycle;
    logic              allow_miss;
    logic              busy [2];
    logic              queued [2];
    int                miss_cycle [2];
    refill_pkg::addr_t miss_addr [2];
    int                served;
    refill_pkg::addr_t served_addr;
    int                resp_count;
    int                lru_order [2][NUM_WAYS];
    int                refills [2];

    refill_unit #(
        .DC_NUM_WAYS (NUM_WAYS),
        .IC_NUM_WAYS (NUM_WAYS)
    ) dut_i (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .dc_miss_i       (dc_miss_i),
        .dc_addr_i       (dc_addr_i),
        .dc_hit_i        (dc_hit_i),
        .dc_hit_way_i    (dc_hit_way_i),
        .dc_store_i      (dc_store_i),
        .dc_store_addr_i (dc_store_addr_i),
        .dc_store_data_i (dc_store_data_i),
        .dc_store_size_i (dc_store_size_i),
        .dc_refill_o     (dc_refill_o),
        .dc_line_o       (dc_line_o),
        .dc_victim_way_o (dc_victim_way_o),
        .ic_miss_i       (ic_miss_i),
        .ic_addr_i       (ic_addr_i),
        .ic_hit_i        (ic_hit_i),
        .ic_hit_way_i    (ic_hit_way_i),
        .ic_refill_o     (ic_refill_o),
        .ic_line_o       (ic_line_o),
        .ic_victim_way_o (ic_victim_way_o),
        .mm_data_rdy_i   (mm_data_rdy_i),
        .mm_data_i       (mm_data_i),
        .mm_rd_req_o     (mm_rd_req_o),
        .mm_addr_o       (mm_addr_o),
        .mm_wr_req_o     (mm_wr_req_o),
        .mm_wr_addr_o    (mm_wr_addr_o),
        .mm_wr_data_o    (mm_wr_data_o),
        .mm_wr_size_o    (mm_wr_size_o)
    );

    bind refill_unit refill_unit_properties u_properties (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .rd_req_i     (mm_rd_req_o),
        .dc_refill_i  (dc_refill_o),
        .ic_refill_i  (ic_refill_o),
        .dc_pending_i (dc_pending),
        .ic_pending_i (ic_pending)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(int n);
        return int'(next_rand() >> 8) % n;
    endfunction

    function automatic refill_pkg::addr_t line_base(refill_pkg::addr_t a);
        return a & ~refill_pkg::addr_t'((1 << refill_pkg::LINE_OFFSET_BITS) - 1);
    endfunction

    // Memory contents are a fixed mix of the line address
    function automatic refill_pkg::line_t line_for(refill_pkg::addr_t a);
        return {a ^ 32'h5a0f_c3e1, ~a, {a[15:0], a[31:16]}, a + 32'h1357_9bdf};
    endfunction

    function automatic logic eligible(int c);
        // Captured at least one edge before the arbiter decides
        return queued[c] && (miss_cycle[c] <= cycle - 2);
    endfunction

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] t=%0t %s expected %b actual %b",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_addr(string name, refill_pkg::addr_t exp, refill_pkg::addr_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] t=%0t %s expected %h actual %h",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_line(string name, refill_pkg::line_t exp, refill_pkg::line_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] t=%0t %s expected %h actual %h",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_way(string name, way_t exp, way_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] t=%0t %s expected %0d actual %0d",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_word(string name, refill_pkg::word_t exp, refill_pkg::word_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] t=%0t %s expected %h actual %h",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_size(string name, refill_pkg::mem_size_t exp,
                              refill_pkg::mem_size_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] t=%0t %s expected %0d actual %0d",
                                    $time, name, exp, act));
        end
    endtask

    // Move a way to the most recent end of the order
    task automatic lru_touch(int c, int way);
        int pos;
        pos = 0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (lru_order[c][i] == way) begin
                pos = i;
            end
        end
        for (int i = pos; i < NUM_WAYS - 1; i++) begin
            lru_order[c][i] = lru_order[c][i + 1];
        end
        lru_order[c][NUM_WAYS - 1] = way;
    endtask

    task automatic take_refill(int c, string name, refill_pkg::line_t line, way_t victim);
        if (served != c) begin
            stop_on_error($sformatf("Refill pulse for %s at %0t without a read served for it",
                                    name, $time));
        end else begin
            check_line({name, "_line_o"}, line_for(served_addr), line);
            check_way({name, "_victim_way_o"}, way_t'(lru_order[c][0]), victim);
            lru_touch(c, lru_order[c][0]);
            served = -1;
            busy[c] = 1'b0;
            refills[c]++;
        end
    endtask

    task automatic take_request();
        int c;
        c = -1;
        if (eligible(0)) begin
            c = 0;
        end else if (eligible(1)) begin
            c = 1;
        end
        if (served != -1) begin
            stop_on_error($sformatf("Read request at %0t while another refill is outstanding",
                                    $time));
        end else if (c < 0) begin
            stop_on_error($sformatf("Read request at %0t with no pending miss", $time));
        end else begin
            check_addr("mm_addr_o", line_base(miss_addr[c]), mm_addr_o);
            queued[c] = 1'b0;
            served = c;
            served_addr = line_base(miss_addr[c]);
            // Answer after 1 to MAX_MEM_DELAY cycles
            resp_count = 2 + rand_below(MAX_MEM_DELAY);
        end
    endtask

    task automatic start_miss(int c, refill_pkg::addr_t a);
        busy[c] = 1'b1;
        queued[c] = 1'b1;
        miss_cycle[c] = cycle;
        miss_addr[c] = a;
    endtask

    task automatic drive_inputs();
        int pick;
        dc_miss_i = 1'b0;
        ic_miss_i = 1'b0;
        dc_hit_i = 1'b0;
        ic_hit_i = 1'b0;
        dc_addr_i = next_rand();
        ic_addr_i = next_rand();
        dc_hit_way_i = way_t'(rand_below(NUM_WAYS));
        ic_hit_way_i = way_t'(rand_below(NUM_WAYS));
        mm_data_rdy_i = 1'b0;
        mm_data_i = {next_rand(), next_rand(), next_rand(), next_rand()};
        if (resp_count > 0) begin
            resp_count--;
            if (resp_count == 0) begin
                mm_data_rdy_i = 1'b1;
                mm_data_i = line_for(served_addr);
            end
        end
        // A stalled cache neither hits nor misses
        if (!busy[0] && !dc_refill_o) begin
            pick = rand_below(8);
            if (pick < 2 && allow_miss) begin
                dc_miss_i = 1'b1;
                start_miss(0, dc_addr_i);
            end else if (pick >= 5) begin
                dc_hit_i = 1'b1;
                lru_touch(0, int'(dc_hit_way_i));
            end
        end
        if (!busy[1] && !ic_refill_o) begin
            pick = rand_below(8);
            if (pick < 2 && allow_miss) begin
                ic_miss_i = 1'b1;
                start_miss(1, ic_addr_i);
            end else if (pick >= 5) begin
                ic_hit_i = 1'b1;
                lru_touch(1, int'(ic_hit_way_i));
            end
        end
        dc_store_i = (rand_below(3) == 0);
        dc_store_addr_i = next_rand();
        dc_store_data_i = next_rand();
        dc_store_size_i = refill_pkg::mem_size_t'(rand_below(3));
    endtask

    task automatic run_cycle();
        @(negedge clk_i);
        cycle++;
        if (dc_refill_o) begin
            take_refill(0, "dc", dc_line_o, dc_victim_way_o);
        end
        if (ic_refill_o) begin
            take_refill(1, "ic", ic_line_o, ic_victim_way_o);
        end
        if (mm_rd_req_o) begin
            take_request();
        end else if (served == -1 && (eligible(0) || eligible(1))) begin
            stop_on_error($sformatf("Pending miss not requested from memory at %0t", $time));
        end
        drive_inputs();
        // Stores pass through within the same cycle
        #1;
        check_bit("mm_wr_req_o", dc_store_i, mm_wr_req_o);
        check_addr("mm_wr_addr_o", dc_store_addr_i, mm_wr_addr_o);
        check_word("mm_wr_data_o", dc_store_data_i, mm_wr_data_o);
        check_size("mm_wr_size_o", dc_store_size_i, mm_wr_size_o);
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_on_error($sformatf("Watchdog expired at %0t before %0d refills were checked",
                                $time, NUM_REFILLS));
    end

    initial begin
        lcg_state = 32'h47a9_452c;
        cycle = 0;
        allow_miss = 1'b0;
        served = -1;
        served_addr = '0;
        resp_count = 0;
        for (int c = 0; c < 2; c++) begin
            busy[c] = 1'b0;
            queued[c] = 1'b0;
            miss_cycle[c] = 0;
            miss_addr[c] = '0;
            refills[c] = 0;
            for (int i = 0; i < NUM_WAYS; i++) begin
                lru_order[c][i] = i;
            end
        end
        clk_i = 1'b0;
        arst_n_i = 1'b0;
        dc_miss_i = 1'b0;
        dc_addr_i = '0;
        dc_hit_i = 1'b0;
        dc_hit_way_i = '0;
        dc_store_i = 1'b0;
        dc_store_addr_i = '0;
        dc_store_data_i = '0;
        dc_store_size_i = '0;
        ic_miss_i = 1'b0;
        ic_addr_i = '0;
        ic_hit_i = 1'b0;
        ic_hit_way_i = '0;
        mm_data_rdy_i = 1'b0;
        mm_data_i = '0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        arst_n_i = 1'b1;
        check_way("dc_victim_way_o", '0, dc_victim_way_o);
        check_way("ic_victim_way_o", '0, ic_victim_way_o);
        // Quiet stretch with hits and stores only
        repeat (IDLE_CYCLES) run_cycle();
        allow_miss = 1'b1;
        while (refills[0] + refills[1] < NUM_REFILLS) begin
            run_cycle();
        end
        $display("Refills checked: dc %0d, ic %0d", refills[0], refills[1]);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
